// ==== src/demo_pkg.sv ====
package demo_pkg;

  // PWM level counter and threshold width, one frame is 2**PWM_W cycles
  localparam int PWM_W = 11;

  // FIFO depths as log2
  localparam int AUDIO_DEPTH_LOG2 = 9;
  localparam int LOOP_DEPTH_LOG2 = 11;

  // Seekable memory, 32 bytes
  localparam int MEM_ADDR_W = 5;

  // Lite register file, 32 words addressed by byte
  localparam int LITE_IDX_W = 5;
  localparam int LITE_ADDR_W = 7;

  typedef logic [7:0] byte_t;

  // Stereo sample, right channel in the upper half
  typedef struct packed {
    logic signed [15:0] right;
    logic signed [15:0] left;
  } audio_sample_t;

  // Write side of the 8-bit loopback stream
  typedef struct packed {
    logic  wren;
    byte_t data;
  } stream8_req_t;

  // Write side of the 32-bit audio stream
  typedef struct packed {
    logic          wren;
    audio_sample_t sample;
  } audio_req_t;

  typedef struct packed {
    logic                  wren;
    logic                  rden;
    logic [MEM_ADDR_W-1:0] addr;
    byte_t                 wdata;
  } mem_req_t;

  // Bus side sees a word, register file sees four byte lanes
  typedef union packed {
    logic [31:0]     word;
    byte_t [3:0]     lanes;
  } lite_word_u;

  typedef struct packed {
    logic                   rden;
    logic [3:0]             wstrb;
    logic [LITE_ADDR_W-1:0] addr;
    lite_word_u             wdata;
  } lite_req_t;

endpackage

// ==== src/sync_fifo.sv ====
module sync_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic             bus_clk,
  input  logic             flush_i,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [WIDTH-1:0]      mem [0:(1 << DEPTH_LOG2)-1];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  // One extra bit so that a full buffer is distinct from an empty one
  logic [DEPTH_LOG2:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  // Writes while full and reads while empty are dropped
  assign do_wr = wr_en_i && !full_o && !flush_i;
  assign do_rd = rd_en_i && !empty_o && !flush_i;

  assign empty_o = (count == '0);
  // Count never exceeds the depth, so the top bit alone marks full
  assign full_o  = count[DEPTH_LOG2];

  always_ff @(posedge bus_clk)
  begin
    if (flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read data register
  always_ff @(posedge bus_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= din_i;
    if (do_rd)
      dout_o <= mem[rd_ptr];
  end

endmodule

// ==== src/pwm_audio.sv ====
module pwm_audio
  import demo_pkg::*;
(
  input  logic          bus_clk,
  input  logic          rst_i,
  input  audio_sample_t fifo_dout_i,
  input  logic          fifo_empty_i,
  output logic          fifo_rd_en_o,
  output logic          pwm_left_o,
  output logic          pwm_right_o
);

  logic [PWM_W-1:0] pwm_level;
  logic [PWM_W-1:0] threshold_left;
  logic [PWM_W-1:0] threshold_right;
  logic             sample_held;
  logic             frame_end;

  // Signed sample to offset binary, keeping the top PWM_W bits
  function automatic logic [PWM_W-1:0] to_threshold(input logic signed [15:0] chan);
    logic [PWM_W-1:0] top;
    top = chan[15 -: PWM_W];
    return top + PWM_W'(1 << (PWM_W - 1));
  endfunction

  assign frame_end = (pwm_level == '1);

  // Fetch the next sample as soon as the last one has been consumed
  assign fifo_rd_en_o = !sample_held && !fifo_empty_i;

  always_ff @(posedge bus_clk)
  begin
    if (rst_i)
    begin
      pwm_level       <= '0;
      threshold_left  <= '0;
      threshold_right <= '0;
      sample_held     <= 1'b0;
      pwm_left_o      <= 1'b0;
      pwm_right_o     <= 1'b0;
    end
    else
    begin
      pwm_level <= pwm_level + 1'b1;

      if (frame_end)
      begin
        if (sample_held)
        begin
          threshold_left  <= to_threshold(fifo_dout_i.left);
          threshold_right <= to_threshold(fifo_dout_i.right);
        end
        else
        begin
          // Underrun, stay silent for this frame
          threshold_left  <= '0;
          threshold_right <= '0;
        end
      end

      // A read only happens with nothing held, so no conflict with release
      if (fifo_rd_en_o)
        sample_held <= 1'b1;
      else if (frame_end)
        sample_held <= 1'b0;

      pwm_left_o  <= (threshold_left > pwm_level);
      pwm_right_o <= (threshold_right > pwm_level);
    end
  end

endmodule

// ==== src/seek_ram.sv ====
module seek_ram
  import demo_pkg::*;
(
  input  logic     bus_clk,
  input  mem_req_t req_i,
  output byte_t    rdata_o
);

  byte_t mem [0:(1 << MEM_ADDR_W)-1];

  // Read sees the byte from before a same-cycle write
  always_ff @(posedge bus_clk)
  begin
    if (req_i.wren)
      mem[req_i.addr] <= req_i.wdata;
    if (req_i.rden)
      rdata_o <= mem[req_i.addr];
  end

endmodule

// ==== src/lite_regs.sv ====
module lite_regs
  import demo_pkg::*;
(
  input  logic       bus_clk,
  input  lite_req_t  req_i,
  output lite_word_u rd_data_o
);

  // One byte array per lane, so each strobe writes its own array
  byte_t lane_mem [0:3][0:(1 << LITE_IDX_W)-1];
  logic [LITE_IDX_W-1:0] word_idx;

  // Byte address to word index
  assign word_idx = req_i.addr[LITE_IDX_W+1:2];

  always_ff @(posedge bus_clk)
  begin
    for (int l = 0; l < 4; l++)
    begin
      if (req_i.wstrb[l])
        lane_mem[l][word_idx] <= req_i.wdata.lanes[l];
    end

    // Old lane contents on a same-cycle write
    if (req_i.rden)
    begin
      for (int l = 0; l < 4; l++)
        rd_data_o.lanes[l] <= lane_mem[l][word_idx];
    end
  end

endmodule

// ==== src/stream_demo_top.sv ====
module stream_demo_top
  import demo_pkg::*;
(
  input  logic         bus_clk,
  input  logic         rst_i,

  input  logic         write32_open_i,
  input  audio_req_t   audio_req_i,
  output logic         write32_full_o,

  input  logic         write8_open_i,
  input  logic         read8_open_i,
  input  stream8_req_t loop_req_i,
  output logic         write8_full_o,
  input  logic         read8_rden_i,
  output byte_t        read8_data_o,
  output logic         read8_empty_o,

  input  mem_req_t     mem_req_i,
  output byte_t        mem_rdata_o,

  input  lite_req_t    lite_req_i,
  output lite_word_u   lite_rd_data_o,

  output logic         pwm_left_o,
  output logic         pwm_right_o
);

  logic          audio_flush;
  logic          loop_flush;
  audio_sample_t audio_dout;
  logic          audio_empty;
  logic          audio_rd_en;

  // Audio FIFO drops its contents when the host closes the stream
  assign audio_flush = rst_i || !write32_open_i;
  // Loopback keeps its data while either side is still open
  assign loop_flush  = rst_i || (!write8_open_i && !read8_open_i);

  sync_fifo #(
    .WIDTH      (32),
    .DEPTH_LOG2 (AUDIO_DEPTH_LOG2)
  ) u_audio_fifo (
    .bus_clk (bus_clk),
    .flush_i (audio_flush),
    .wr_en_i (audio_req_i.wren),
    .din_i   (audio_req_i.sample),
    .rd_en_i (audio_rd_en),
    .dout_o  (audio_dout),
    .full_o  (write32_full_o),
    .empty_o (audio_empty)
  );

  pwm_audio u_pwm_audio (
    .bus_clk      (bus_clk),
    .rst_i        (rst_i),
    .fifo_dout_i  (audio_dout),
    .fifo_empty_i (audio_empty),
    .fifo_rd_en_o (audio_rd_en),
    .pwm_left_o   (pwm_left_o),
    .pwm_right_o  (pwm_right_o)
  );

  sync_fifo #(
    .WIDTH      (8),
    .DEPTH_LOG2 (LOOP_DEPTH_LOG2)
  ) u_loop_fifo (
    .bus_clk (bus_clk),
    .flush_i (loop_flush),
    .wr_en_i (loop_req_i.wren),
    .din_i   (loop_req_i.data),
    .rd_en_i (read8_rden_i),
    .dout_o  (read8_data_o),
    .full_o  (write8_full_o),
    .empty_o (read8_empty_o)
  );

  seek_ram u_seek_ram (
    .bus_clk (bus_clk),
    .req_i   (mem_req_i),
    .rdata_o (mem_rdata_o)
  );

  lite_regs u_lite_regs (
    .bus_clk   (bus_clk),
    .req_i     (lite_req_i),
    .rd_data_o (lite_rd_data_o)
  );

endmodule

// ==== sim/stream_demo_chk.sv ====
module stream_demo_chk (
  input logic bus_clk,
  input logic rst_i,
  input logic wr8_open_i,
  input logic rd8_open_i,
  input logic rd8_empty_i,
  input logic wr8_full_i,
  input logic pwm_left_i,
  input logic pwm_right_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic loop_flush;

  // Same flush condition as the loopback FIFO sees
  assign loop_flush = rst_i || (!wr8_open_i && !rd8_open_i);

  a_not_empty_and_full: assert property (
    @(posedge bus_clk) disable iff (rst_i) !(rd8_empty_i && wr8_full_i)
  ) else $error("Loopback FIFO shows empty and full at once");

  a_pwm_low_after_reset: assert property (
    @(posedge bus_clk) rst_i |=> (!pwm_left_i && !pwm_right_i)
  ) else $error("PWM output high in the cycle after reset");

  a_empty_after_flush: assert property (
    @(posedge bus_clk) loop_flush |=> rd8_empty_i
  ) else $error("Loopback FIFO not empty one cycle after a flush");

endmodule

bind stream_demo_top stream_demo_chk u_chk (
  .bus_clk     (bus_clk),
  .rst_i       (rst_i),
  .wr8_open_i  (write8_open_i),
  .rd8_open_i  (read8_open_i),
  .rd8_empty_i (read8_empty_o),
  .wr8_full_i  (write8_full_o),
  .pwm_left_i  (pwm_left_o),
  .pwm_right_i (pwm_right_o)
);

// ==== sim/tb_stream_demo.sv ====
module tb_stream_demo
  import demo_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 8;
  localparam int FRAME = 1 << PWM_W;
  localparam int LOOP_DEPTH = 1 << LOOP_DEPTH_LOG2;
  localparam int LOOP_ORDER_CYCLES = 3000;
  localparam int MEM_CYCLES = 600;
  localparam int LITE_CYCLES = 600;
  localparam int AUDIO_PLAY_FRAMES = 11;
  // Audio gets 20 frames and audio flush gets 4
  localparam int WATCHDOG_CYCLES = 8 + LOOP_ORDER_CYCLES + 3 * LOOP_DEPTH + 32
    + MEM_CYCLES + LITE_CYCLES + 64 + 24 * FRAME + 2000;

  logic         bus_clk;
  logic         rst;
  logic         write32_open;
  audio_req_t   audio_req;
  logic         write32_full;
  logic         write8_open;
  logic         read8_open;
  stream8_req_t loop_req;
  logic         write8_full;
  logic         read8_rden;
  byte_t        read8_data;
  logic         read8_empty;
  mem_req_t     mem_req;
  byte_t        mem_rdata;
  lite_req_t    lite_req;
  lite_word_u   lite_rd_data;
  logic         pwm_left;
  logic         pwm_right;

  integer     seed;
  int         pass_count;
  int         fail_count;
  // Reference models
  byte_t      loop_model[$];
  byte_t      mem_model [0:31];
  lite_word_u lite_model [0:31];
  int         exp_left_total;
  int         exp_right_total;
  int         left_high;
  int         right_high;
  // Reads in flight are checked one cycle later
  logic       loop_rd_pending;
  byte_t      loop_exp;
  logic       mem_rd_pending;
  byte_t      mem_exp;
  logic       lite_rd_pending;
  lite_word_u lite_exp;

  stream_demo_top dut_i (
    .bus_clk        (bus_clk),
    .rst_i          (rst),
    .write32_open_i (write32_open),
    .audio_req_i    (audio_req),
    .write32_full_o (write32_full),
    .write8_open_i  (write8_open),
    .read8_open_i   (read8_open),
    .loop_req_i     (loop_req),
    .write8_full_o  (write8_full),
    .read8_rden_i   (read8_rden),
    .read8_data_o   (read8_data),
    .read8_empty_o  (read8_empty),
    .mem_req_i      (mem_req),
    .mem_rdata_o    (mem_rdata),
    .lite_req_i     (lite_req),
    .lite_rd_data_o (lite_rd_data),
    .pwm_left_o     (pwm_left),
    .pwm_right_o    (pwm_right)
  );

  initial
  begin
    bus_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
  end

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act === exp)
      pass_count++;
    else
    begin
      fail_count++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input lite_word_u exp, input lite_word_u act);
    if (act.word === exp.word)
      pass_count++;
    else
    begin
      fail_count++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp.word, act.word);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act == exp)
      pass_count++;
    else
    begin
      fail_count++;
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int start_fail);
    $display("%s finished with %0d failed checks", name, fail_count - start_fail);
  endtask

  // Offset threshold is the top 11 bits of the channel plus half a frame
  function automatic int expected_threshold(input logic [15:0] chan);
    return ((int'(chan) >> (16 - PWM_W)) + FRAME / 2) % FRAME;
  endfunction

  task automatic loop_cycle(input logic wr, input byte_t data, input logic rd);
    logic rd_ok;
    logic wr_ok;
    @(negedge bus_clk);
    if (loop_rd_pending)
      check_byte("read8_data_o", loop_exp, read8_data);
    check_count("read8_empty_o", int'(loop_model.size() == 0), int'(read8_empty));
    check_count("write8_full_o", int'(loop_model.size() == LOOP_DEPTH), int'(write8_full));
    loop_req.wren = wr;
    loop_req.data = data;
    read8_rden = rd;
    rd_ok = rd && (loop_model.size() != 0);
    wr_ok = wr && (loop_model.size() != LOOP_DEPTH);
    loop_rd_pending = rd_ok;
    if (rd_ok)
      loop_exp = loop_model.pop_front();
    if (wr_ok)
      loop_model.push_back(data);
  endtask

  // Close both loopback ends for one cycle
  task automatic flush_loop();
    @(negedge bus_clk);
    write8_open = 1'b0;
    read8_open = 1'b0;
    @(negedge bus_clk);
    check_count("read8_empty_o after flush", 1, int'(read8_empty));
    check_count("write8_full_o after flush", 0, int'(write8_full));
    write8_open = 1'b1;
    read8_open = 1'b1;
    loop_model.delete();
    loop_rd_pending = 1'b0;
  endtask

  task automatic mem_cycle(input logic wr, input logic rd,
                           input logic [MEM_ADDR_W-1:0] addr, input byte_t data);
    @(negedge bus_clk);
    if (mem_rd_pending)
      check_byte("mem_rdata_o", mem_exp, mem_rdata);
    mem_req.wren = wr;
    mem_req.rden = rd;
    mem_req.addr = addr;
    mem_req.wdata = data;
    mem_rd_pending = rd;
    // Read returns the byte from before a same-cycle write
    if (rd)
      mem_exp = mem_model[addr];
    if (wr)
      mem_model[addr] = data;
  endtask

  task automatic lite_cycle(input logic rd, input logic [3:0] strb,
                            input logic [LITE_ADDR_W-1:0] addr, input lite_word_u data);
    logic [LITE_IDX_W-1:0] idx;
    idx = addr[6:2];
    @(negedge bus_clk);
    if (lite_rd_pending)
      check_word("lite_rd_data_o", lite_exp, lite_rd_data);
    lite_req.rden = rd;
    lite_req.wstrb = strb;
    lite_req.addr = addr;
    lite_req.wdata = data;
    lite_rd_pending = rd;
    if (rd)
      lite_exp = lite_model[idx];
    for (int l = 0; l < 4; l++)
    begin
      if (strb[l])
        lite_model[idx].word[8*l +: 8] = data.word[8*l +: 8];
    end
  endtask

  task automatic run_audio_cycles(input int cycles);
    repeat (cycles)
    begin
      @(negedge bus_clk);
      left_high += int'(pwm_left);
      right_high += int'(pwm_right);
    end
  endtask

  // Pushes samples on consecutive cycles while counting PWM highs
  task automatic write_samples(input int count, input logic add_to_model);
    audio_sample_t s;
    for (int i = 0; i < count; i++)
    begin
      run_audio_cycles(1);
      s = audio_sample_t'($random(seed));
      audio_req.wren = 1'b1;
      audio_req.sample = s;
      if (add_to_model)
      begin
        exp_left_total += expected_threshold(s.left);
        exp_right_total += expected_threshold(s.right);
      end
    end
    run_audio_cycles(1);
    audio_req.wren = 1'b0;
  endtask

  task automatic run_tests();
    logic [31:0] rnd;
    lite_word_u  wdata;
    int          start_fail;

    start_fail = fail_count;
    for (int i = 0; i < LOOP_ORDER_CYCLES; i++)
    begin
      rnd = $random(seed);
      loop_cycle(rnd[0] | rnd[1], rnd[15:8], rnd[2]);
    end
    loop_cycle(1'b0, 8'h00, 1'b0);
    report_test("loopback order", start_fail);

    start_fail = fail_count;
    flush_loop();
    for (int i = 0; i < LOOP_DEPTH; i++)
    begin
      rnd = $random(seed);
      loop_cycle(1'b1, rnd[7:0], 1'b0);
    end
    // FIFO is full so this byte is dropped
    loop_cycle(1'b1, 8'ha5, 1'b0);
    for (int i = 0; i < LOOP_DEPTH; i++)
      loop_cycle(1'b0, 8'h00, 1'b1);
    // Refill so the flush starts from a full FIFO
    for (int i = 0; i < LOOP_DEPTH; i++)
      loop_cycle(1'b1, 8'(i + 1), 1'b0);
    loop_cycle(1'b0, 8'h00, 1'b0);
    flush_loop();
    report_test("loopback full and flush", start_fail);

    start_fail = fail_count;
    for (int a = 0; a < 32; a++)
    begin
      rnd = $random(seed);
      mem_cycle(1'b1, 1'b0, MEM_ADDR_W'(a), rnd[7:0]);
    end
    for (int i = 0; i < MEM_CYCLES; i++)
    begin
      rnd = $random(seed);
      mem_cycle(rnd[0], rnd[1], rnd[12:8], rnd[23:16]);
    end
    mem_cycle(1'b0, 1'b0, '0, 8'h00);
    report_test("seekable memory", start_fail);

    start_fail = fail_count;
    for (int w = 0; w < 32; w++)
    begin
      wdata.word = $random(seed);
      lite_cycle(1'b0, 4'hf, {LITE_IDX_W'(w), 2'b00}, wdata);
    end
    for (int i = 0; i < LITE_CYCLES; i++)
    begin
      rnd = $random(seed);
      wdata.word = $random(seed);
      lite_cycle(rnd[0], rnd[7:4], rnd[14:8], wdata);
    end
    lite_cycle(1'b0, 4'h0, '0, wdata);
    report_test("lite registers", start_fail);

    start_fail = fail_count;
    left_high = 0;
    right_high = 0;
    exp_left_total = 0;
    exp_right_total = 0;
    write_samples(8, 1'b1);
    check_count("write32_full_o", 0, int'(write32_full));
    run_audio_cycles(AUDIO_PLAY_FRAMES * FRAME);
    check_count("pwm_left_o high cycles", exp_left_total, left_high);
    check_count("pwm_right_o high cycles", exp_right_total, right_high);
    left_high = 0;
    right_high = 0;
    run_audio_cycles(FRAME);
    check_count("pwm_left_o high cycles after drain", 0, left_high);
    check_count("pwm_right_o high cycles after drain", 0, right_high);
    report_test("pwm audio", start_fail);

    start_fail = fail_count;
    @(negedge bus_clk);
    write32_open = 1'b0;
    write_samples(8, 1'b0);
    run_audio_cycles(3 * FRAME);
    check_count("pwm_left_o high cycles while closed", 0, left_high);
    check_count("pwm_right_o high cycles while closed", 0, right_high);
    write32_open = 1'b1;
    report_test("audio flush", start_fail);
  endtask

  initial
  begin
    seed = 32'h6f66;
    pass_count = 0;
    fail_count = 0;
    loop_rd_pending = 1'b0;
    mem_rd_pending = 1'b0;
    lite_rd_pending = 1'b0;
    rst = 1'b1;
    write32_open = 1'b1;
    write8_open = 1'b1;
    read8_open = 1'b1;
    audio_req = '0;
    loop_req = '0;
    read8_rden = 1'b0;
    mem_req = '0;
    lite_req = '0;
    repeat (8) @(negedge bus_clk);
    rst = 1'b0;
    run_tests();
    $display("Summary: %0d checks passed, %0d checks failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== build.f ====
src/demo_pkg.sv
src/sync_fifo.sv
src/pwm_audio.sv
src/seek_ram.sv
src/lite_regs.sv
src/stream_demo_top.sv
sim/stream_demo_chk.sv
sim/tb_stream_demo.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
verilator --binary --timing --assert --top-module tb_stream_demo -f build.f > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_stream_demo > sim.log 2>&1
sim_status=$?
cat sim.log
# Any fail message in the log fails the run
grep -q "Test failures found" sim.log && exit 1
[ "$sim_status" -eq 0 ] && grep -q "All tests passed!" sim.log || exit 1
exit 0
